// File: vlog.f
sort_pkg.sv
fifo_pkg.sv
key_fifo.sv
merge_core.sv
run_merger.sv
tb_clock_gen.sv
tb_run_merger.sv

// File: Bender.yml
package:
  name: run_merger

sources:
  # packages first, then the design in compile order
  - sort_pkg.sv
  - fifo_pkg.sv
  - key_fifo.sv
  - merge_core.sv
  - run_merger.sv
  # testbench
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_run_merger.sv

// File: tb_run_merger.sv
module tb_run_merger
   import sort_pkg::*;
();

   timeunit 1ns;
   timeprecision 10ps;

   // output words per test with the random test at its largest
   localparam int WORDS_BASIC     = 11;
   localparam int WORDS_EMPTY     = 14;
   localparam int WORDS_DUP       = 11;
   localparam int WORDS_BP        = 31;
   localparam int WORDS_CONSEC    = 22;
   localparam int RAND_PAIRS      = 4;
   localparam int WORDS_RAND      = RAND_PAIRS * 15;
   localparam int WORDS_TOTAL     = WORDS_BASIC + WORDS_EMPTY + WORDS_DUP + WORDS_BP +
                                    WORDS_CONSEC + WORDS_RAND;
   localparam int WATCHDOG_CYCLES = WORDS_TOTAL * 40 + 1000;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic i_clk;
   logic i_rst_n;
   key_t i_a_key     = '0;
   logic i_a_empty   = 1'b1;
   logic o_a_read;
   key_t i_b_key     = '0;
   logic i_b_empty   = 1'b1;
   logic o_b_read;
   logic i_out_ready = 1'b0;
   key_t o_out_key;
   logic o_out_write;

   // upstream models, runs being built, golden and collected output
   key_t stream_a [$];
   key_t stream_b [$];
   key_t run_a [$];
   key_t run_b [$];
   key_t expected [$];
   key_t got [$];

   logic [31:0] lfsr_state = 32'ha44b;
   logic        gap_a_en   = 1'b0;
   logic        gap_b_en   = 1'b0;
   logic        bp_en      = 1'b0;
   int          err_count  = 0;
   int          err_mark   = 0;
   int          pass_count = 0;
   int          fail_count = 0;

   tb_clock_gen clock_gen (
      .o_clk   (i_clk),
      .o_rst_n (i_rst_n)
   );

   run_merger uut (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_key     (i_a_key),
      .i_a_empty   (i_a_empty),
      .o_a_read    (o_a_read),
      .i_b_key     (i_b_key),
      .i_b_empty   (i_b_empty),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out_key   (o_out_key),
      .o_out_write (o_out_write)
   );

   ////////////////////
   // random bits

   // galois form with the lsb shifting out
   function automatic logic rand_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   ////////////////////
   // stream models

   // upstream and downstream inputs change on the falling edge
   always @(negedge i_clk) begin
      if (stream_a.size() == 0 || (gap_a_en && rand_bit())) begin
         i_a_empty <= 1'b1;
         i_a_key   <= '0;
      end else begin
         i_a_empty <= 1'b0;
         i_a_key   <= stream_a[0];
      end
      if (stream_b.size() == 0 || (gap_b_en && rand_bit())) begin
         i_b_empty <= 1'b1;
         i_b_key   <= '0;
      end else begin
         i_b_empty <= 1'b0;
         i_b_key   <= stream_b[0];
      end
      i_out_ready <= bp_en ? rand_bit() : 1'b1;
   end

   // reads take the front key and writes land in the collector
   always @(posedge i_clk) begin
      if (o_a_read && stream_a.size() > 0) begin
         void'(stream_a.pop_front());
      end
      if (o_b_read && stream_b.size() > 0) begin
         void'(stream_b.pop_front());
      end
      if (o_out_write) begin
         got.push_back(o_out_key);
      end
   end

   ////////////////////
   // helpers

   task automatic compare_value(input string sig, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      if (exp_v !== act_v) begin
         $display("FAILED %s expected 0x%08h actual 0x%08h", sig, exp_v, act_v);
         err_count++;
      end
   endtask

   task automatic add_key(input bit to_b, input key_t k);
      if (to_b) begin
         run_b.push_back(k);
      end else begin
         run_a.push_back(k);
      end
   endtask

   task automatic fill_run(input bit to_b, input int n, input int start, input int step);
      for (int i = 0; i < n; i++) begin
         add_key(to_b, key_t'(start + i * step));
      end
   endtask

   // nondecreasing and never zero
   task automatic random_run(input bit to_b, input int n);
      key_t k;
      k = 1 + rand_bits(8);
      for (int i = 0; i < n; i++) begin
         add_key(to_b, k);
         k = k + rand_bits(4);
      end
   endtask

   // insertion into the tail of the golden list starting at base
   task automatic sort_into_expected(input key_t k, input int base);
      int   j;
      key_t t;
      expected.push_back(k);
      j = expected.size() - 1;
      while (j > base && expected[j-1] > expected[j]) begin
         t             = expected[j-1];
         expected[j-1] = expected[j];
         expected[j]   = t;
         j--;
      end
   endtask

   // sends both runs with their markers and the golden list gets the sorted union
   task automatic queue_run_pair();
      int base;
      base = expected.size();
      foreach (run_a[i]) begin
         stream_a.push_back(run_a[i]);
         sort_into_expected(run_a[i], base);
      end
      foreach (run_b[i]) begin
         stream_b.push_back(run_b[i]);
         sort_into_expected(run_b[i], base);
      end
      stream_a.push_back(RUN_END);
      stream_b.push_back(RUN_END);
      expected.push_back(RUN_END);
      run_a.delete();
      run_b.delete();
   endtask

   // starts just after the rising edge and clear of both stream processes
   task automatic begin_test();
      @(posedge i_clk);
      #1;
      got.delete();
      expected.delete();
      err_mark = err_count;
   endtask

   task automatic collect_output(input int num);
      int waited;
      int limit;
      int n;
      limit  = expected.size() * 40 + 200;
      waited = 0;
      while (got.size() < expected.size() && waited < limit) begin
         @(posedge i_clk);
         #1;
         waited++;
      end
      if (got.size() < expected.size()) begin
         $display("test %0d: only %0d of %0d output words arrived",
                  num, got.size(), expected.size());
         err_count++;
      end else begin
         // nothing more may come out during a quiet period
         repeat (20) @(posedge i_clk);
         #1;
         if (got.size() > expected.size()) begin
            $display("test %0d: %0d output words arrived, %0d were expected",
                     num, got.size(), expected.size());
            err_count++;
         end
      end
      n = (got.size() < expected.size()) ? got.size() : expected.size();
      for (int i = 0; i < n; i++) begin
         compare_value($sformatf("o_out_key[%0d]", i), expected[i], got[i]);
      end
      compare_value("stream_a keys left", 32'd0, stream_a.size());
      compare_value("stream_b keys left", 32'd0, stream_b.size());
      gap_a_en = 1'b0;
      gap_b_en = 1'b0;
      bp_en    = 1'b0;
   endtask

   task automatic report_test(input int num, input string name);
      if (err_count == err_mark) begin
         pass_count++;
         $display("test %0d %s: passed", num, name);
      end else begin
         fail_count++;
         $display("test %0d %s: failed", num, name);
      end
   endtask

   ////////////////////
   // directed tests

   task automatic basic_merge();
      begin_test();
      fill_run(0, 5, 10, 20);
      fill_run(1, 5, 20, 20);
      queue_run_pair();
      collect_output(1);
      report_test(1, "basic merge");
   endtask

   // a bare marker on one side and then on the other
   task automatic empty_side();
      begin_test();
      fill_run(0, 6, 5, 3);
      queue_run_pair();
      fill_run(1, 6, 4, 7);
      queue_run_pair();
      collect_output(2);
      report_test(2, "empty side");
   endtask

   task automatic duplicate_keys();
      begin_test();
      add_key(0, 3);
      add_key(0, 3);
      add_key(0, 7);
      add_key(0, 9);
      add_key(0, 9);
      add_key(1, 3);
      add_key(1, 5);
      add_key(1, 7);
      add_key(1, 7);
      add_key(1, 9);
      queue_run_pair();
      collect_output(3);
      report_test(3, "duplicates and ties");
   endtask

   task automatic output_backpressure();
      begin_test();
      bp_en = 1'b1;
      fill_run(0, 15, 1, 3);
      fill_run(1, 15, 2, 3);
      queue_run_pair();
      collect_output(4);
      report_test(4, "back-pressure");
   endtask

   // second pair sorts below the first so any mixing shows up
   task automatic consecutive_runs();
      int ends;
      begin_test();
      fill_run(0, 4, 100, 10);
      fill_run(1, 3, 105, 10);
      queue_run_pair();
      add_key(0, 50);
      fill_run(1, 5, 10, 20);
      queue_run_pair();
      fill_run(0, 3, 7, 7);
      fill_run(1, 3, 7, 7);
      queue_run_pair();
      collect_output(5);
      ends = 0;
      foreach (got[i]) begin
         if (got[i] == RUN_END) begin
            ends++;
         end
      end
      compare_value("run end count", 32'd3, ends);
      report_test(5, "consecutive runs");
   endtask

   task automatic random_streams();
      begin_test();
      gap_a_en = 1'b1;
      gap_b_en = 1'b1;
      for (int p = 0; p < RAND_PAIRS; p++) begin
         random_run(0, rand_bits(3));
         random_run(1, rand_bits(3));
         queue_run_pair();
      end
      collect_output(6);
      report_test(6, "random streams");
   endtask

   ////////////////////
   // sequence and watchdog

   initial begin
      wait (i_rst_n === 1'b1);
      repeat (2) @(posedge i_clk);
      basic_merge();
      empty_side();
      duplicate_keys();
      output_backpressure();
      consecutive_runs();
      random_streams();
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge i_clk);
      $display("watchdog expired after %0d cycles, the tests did not finish",
               WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 5
) (
   output logic o_clk,
   output logic o_rst_n
);

   timeunit 1ns;
   timeprecision 10ps;

   // 10 ns period
   initial begin
      o_clk = 1'b0;
      forever #HALF_PERIOD o_clk = ~o_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      // release away from the rising edge
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

// File: run_merger.sv
module run_merger
   import sort_pkg::*, fifo_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst_n,
   // upstream stream A
   input  key_t i_a_key,
   input  logic i_a_empty,
   output logic o_a_read,
   // upstream stream B
   input  key_t i_b_key,
   input  logic i_b_empty,
   output logic o_b_read,
   // downstream queue
   input  logic i_out_ready,
   output key_t o_out_key,
   output logic o_out_write
);

   key_t head_a;
   logic head_a_empty;
   logic a_full;
   logic pop_a;

   key_t head_b;
   logic head_b_empty;
   logic b_full;
   logic pop_b;

   key_t merged_key;
   logic merged_push;
   logic out_space;
   logic out_empty;

   ////////////////////
   // strobes

   // take a key when there is a slot or one frees up this cycle
   assign o_a_read = !i_a_empty && (!a_full || pop_a);
   assign o_b_read = !i_b_empty && (!b_full || pop_b);

   // drain whenever the downstream queue has room
   assign o_out_write = i_out_ready && !out_empty;

   ////////////////////
   // input queues

   key_fifo #(
      .DEPTH   (IN_DEPTH)
   ) queue_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (o_a_read),
      .i_key   (i_a_key),
      .i_pop   (pop_a),
      .o_key   (head_a),
      .o_empty (head_a_empty),
      .o_full  (a_full),
      .o_space ()
   );

   key_fifo #(
      .DEPTH   (IN_DEPTH)
   ) queue_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (o_b_read),
      .i_key   (i_b_key),
      .i_pop   (pop_b),
      .o_key   (head_b),
      .o_empty (head_b_empty),
      .o_full  (b_full),
      .o_space ()
   );

   ////////////////////
   // merge

   merge_core core (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_head_a       (head_a),
      .i_head_a_empty (head_a_empty),
      .i_head_b       (head_b),
      .i_head_b_empty (head_b_empty),
      .i_out_space    (out_space),
      .o_pop_a        (pop_a),
      .o_pop_b        (pop_b),
      .o_out_key      (merged_key),
      .o_out_push     (merged_push)
   );

   ////////////////////
   // output queue

   // push is already bounded by o_space, full is not needed here
   key_fifo #(
      .DEPTH   (OUT_DEPTH)
   ) queue_out (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (merged_push),
      .i_key   (merged_key),
      .i_pop   (o_out_write),
      .o_key   (o_out_key),
      .o_empty (out_empty),
      .o_full  (),
      .o_space (out_space)
   );

endmodule

// File: merge_core.sv
module merge_core
   import sort_pkg::*, fifo_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst_n,
   // head of input queue A
   input  key_t i_head_a,
   input  logic i_head_a_empty,
   // head of input queue B
   input  key_t i_head_b,
   input  logic i_head_b_empty,
   // output queue has room for the pipe contents plus one
   input  logic i_out_space,
   // pops into the input queues
   output logic o_pop_a,
   output logic o_pop_b,
   // write into the output queue
   output key_t o_out_key,
   output logic o_out_push
);

   logic                   a_end;
   logic                   b_end;
   logic                   a_le_b;
   logic                   sel_fire;
   logic                   take_a;
   logic                   take_b;
   key_t                   sel_key;

   // stage 0 is the select register, the last stage feeds the output queue
   key_t                   pipe_key [MERGE_SLACK];
   logic [MERGE_SLACK-1:0] pipe_vld;

   ////////////////////
   // head compare

   assign a_end  = (i_head_a == RUN_END);
   assign b_end  = (i_head_b == RUN_END);
   assign a_le_b = (i_head_a <= i_head_b);

   // both heads present and the output queue can absorb the pipe
   assign sel_fire = !i_head_a_empty && !i_head_b_empty && i_out_space;

   ////////////////////
   // merge rule

   always_comb begin
      take_a  = 1'b0;
      take_b  = 1'b0;
      sel_key = i_head_a;
      if (a_end && b_end) begin
         // both runs done, one marker closes the merged run
         take_a  = 1'b1;
         take_b  = 1'b1;
         sel_key = RUN_END;
      end else if (a_end) begin
         // A waits at its marker until B drains
         take_b  = 1'b1;
         sel_key = i_head_b;
      end else if (b_end) begin
         take_a  = 1'b1;
         sel_key = i_head_a;
      end else if (a_le_b) begin
         // ties go to A
         take_a  = 1'b1;
         sel_key = i_head_a;
      end else begin
         take_b  = 1'b1;
         sel_key = i_head_b;
      end
   end

   // combinational so a pop and a refill share a cycle
   assign o_pop_a = sel_fire && take_a;
   assign o_pop_b = sel_fire && take_b;

   ////////////////////
   // pipe valid flags

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= sel_fire;
         for (int i = 1; i < MERGE_SLACK; i++) begin
            pipe_vld[i] <= pipe_vld[i-1];
         end
      end
   end

   ////////////////////
   // pipe keys

   // the pipe never stalls, space was checked at select time
   always_ff @(posedge i_clk) begin
      if (sel_fire) begin
         pipe_key[0] <= sel_key;
      end
      for (int i = 1; i < MERGE_SLACK; i++) begin
         if (pipe_vld[i-1]) begin
            pipe_key[i] <= pipe_key[i-1];
         end
      end
   end

   // key popped at edge n lands in the output queue at edge n+2
   assign o_out_key  = pipe_key[MERGE_SLACK-1];
   assign o_out_push = pipe_vld[MERGE_SLACK-1];

endmodule

// File: key_fifo.sv
module key_fifo
   import sort_pkg::*, fifo_pkg::*;
#(
   parameter int DEPTH = IN_DEPTH
) (
   input  logic i_clk,
   input  logic i_rst_n,
   // write side
   input  logic i_push,
   input  key_t i_key,
   // read side, head shown without latency
   input  logic i_pop,
   output key_t o_key,
   // status
   output logic o_empty,
   output logic o_full,
   output logic o_space
);

   localparam int AW = $clog2(DEPTH);

   key_t           mem [DEPTH];
   logic [AW:0]    wr_ptr;
   logic [AW:0]    rd_ptr;
   logic [AW:0]    count;
   logic [AW:0]    free_cnt;
   logic           do_push;
   logic           do_pop;

   ////////////////////
   // status

   // extra pointer bit tells a full buffer from an empty one
   assign o_empty = (wr_ptr == rd_ptr);
   assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   // room for the keys still in flight plus one more
   assign free_cnt = (AW+1)'(DEPTH) - count;
   assign o_space  = (free_cnt >= (AW+1)'(MERGE_SLACK + 1));

   // a pop frees a slot in the same cycle
   assign do_pop  = i_pop && !o_empty;
   assign do_push = i_push && (!o_full || do_pop);

   ////////////////////
   // pointers and occupancy

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   ////////////////////
   // storage

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr[AW-1:0]] <= i_key;
      end
   end

   // show-ahead head
   assign o_key = mem[rd_ptr[AW-1:0]];

endmodule

// File: fifo_pkg.sv
package fifo_pkg;

   ////////////////////
   // queue sizing

   // input queues, one per upstream stream
   // must be a power of two
   localparam int IN_DEPTH = 8;

   // merged output queue towards the downstream side
   // must be a power of two
   localparam int OUT_DEPTH = 8;

   ////////////////////
   // merge pipeline

   // keys that can sit in the merge pipe before reaching the output queue
   // also the number of pipe stages in merge_core
   localparam int MERGE_SLACK = 2;

endpackage

// File: sort_pkg.sv
package sort_pkg;

   ////////////////////
   // key format

   // width of every key in the sorter
   localparam int KEY_W = 32;

   // one unsigned key word, compared as an unsigned number
   typedef logic [KEY_W-1:0] key_t;

   ////////////////////
   // run framing

   // keys inside a run are nonzero
   // the zero word closes the run
   localparam key_t RUN_END = '0;

endpackage
